// File: source/aes_key_pkg.sv
////////////////////////////////////////////////////////////////////////////
// AES-128 key schedule package
// Key, word, byte and round types, direction and FSM state enums,
// round limits, Rcon start values and GF(2^8) helper functions
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package aes_key_pkg;

  // Word 0 in bits 31:0, byte 0 of each word in its low 8 bits
  typedef logic [127:0] aes_key_t;
  typedef logic [31:0]  aes_word_t;
  typedef logic [7:0]   aes_byte_t;
  typedef logic [3:0]   aes_round_t;

  // Walk direction of the schedule
  typedef enum logic {
    CIPH_FWD = 1'b0,
    CIPH_INV = 1'b1
  } ciph_dir_e;

  // Schedule controller states
  typedef enum logic {
    ST_IDLE   = 1'b0,
    ST_ACTIVE = 1'b1
  } sched_state_e;

  // Last round index of AES-128
  localparam int NumRounds = 10;

  // Rcon for round 1 (forward) and round 10 (inverse)
  localparam aes_byte_t RconFwdInit = 8'h01;
  localparam aes_byte_t RconInvInit = 8'h36;

  // Multiply by x, reduction polynomial 0x11B
  function automatic aes_byte_t aes_mul2(input aes_byte_t b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  // Divide by x, undoes aes_mul2
  // Odd input means the top bit was set before the reduction
  function automatic aes_byte_t aes_div2(input aes_byte_t b);
    return b[0] ? (((b ^ 8'h1b) >> 1) | 8'h80) : (b >> 1);
  endfunction

  // RotWord: byte 1 moves to byte 0, byte 0 wraps to byte 3
  function automatic aes_word_t aes_rot_word(input aes_word_t w);
    return {w[7:0], w[31:8]};
  endfunction

endpackage

`default_nettype wire

// File: source/aes_sbox_lut.sv
////////////////////////////////////////////////////////////////////////////
// Forward AES S-box, one byte, 256-entry look-up table
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module aes_sbox_lut import aes_key_pkg::*; (
  input  aes_byte_t data_i,
  output aes_byte_t data_o
);

  // Indexed by the input byte, row of 8 entries per line
  localparam aes_byte_t SboxTable [256] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  // Pure table read, no latency
  assign data_o = SboxTable[data_i];

endmodule

`default_nettype wire

// File: source/aes_key_sched_fsm.sv
////////////////////////////////////////////////////////////////////////////
// Key schedule controller
// Idle/active FSM producing load and step strobes, status levels
// and the registered done pulse
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module aes_key_sched_fsm import aes_key_pkg::*; #(
  parameter int NumRounds = aes_key_pkg::NumRounds
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic start_i,
  input  logic advance_i,
  input  logic last_round_i,
  output logic load_o,
  output logic step_o,
  output logic key_valid_o,
  output logic busy_o,
  output logic done_o
);

  sched_state_e state_q, state_d;
  logic         finish;
  logic         done_q;
  // Steps taken in the current run
  aes_round_t   steps_q;

  // Start only counts while idle
  assign load_o = (state_q == ST_IDLE) & start_i;
  // Consumer takes the current key and more rounds remain
  assign step_o = (state_q == ST_ACTIVE) & advance_i & ~last_round_i;
  // Consumer takes the final key
  assign finish = (state_q == ST_ACTIVE) & advance_i & last_round_i;

  always_comb begin : next_state
    state_d = state_q;
    unique case (state_q)
      ST_IDLE:   if (start_i) state_d = ST_ACTIVE;
      ST_ACTIVE: if (finish) state_d = ST_IDLE;
      default:   state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : state_reg
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= finish;
    end
  end

  // Run length tracking
  always_ff @(posedge clk_i or negedge rst_ni) begin : step_cnt
    if (!rst_ni) begin
      steps_q <= '0;
    end else if (load_o) begin
      steps_q <= '0;
    end else if (step_o) begin
      steps_q <= steps_q + 1'b1;
    end
  end

  // Key stays valid for the whole active phase
  assign key_valid_o = (state_q == ST_ACTIVE);
  assign busy_o      = (state_q == ST_ACTIVE);
  assign done_o      = done_q;

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  // One pulse per run, never back to back
  done_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |=> !done_o);

  // Counter must report the last round after exactly NumRounds steps
  done_after_full_run: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |-> (steps_q == NumRounds));

endmodule

`default_nettype wire

// File: source/aes_round_counter.sv
////////////////////////////////////////////////////////////////////////////
// Round counter
// Up count forward, down count inverse, last-round flag
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module aes_round_counter import aes_key_pkg::*; #(
  parameter int NumRounds = aes_key_pkg::NumRounds
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       load_i,
  input  logic       step_i,
  input  ciph_dir_e  dir_i,
  output aes_round_t round_o,
  output logic       last_round_o
);

  aes_round_t round_q;
  ciph_dir_e  dir_q;

  // Forward starts at 0, inverse at the top round
  always_ff @(posedge clk_i or negedge rst_ni) begin : round_reg
    if (!rst_ni) begin
      round_q <= '0;
      dir_q   <= CIPH_FWD;
    end else if (load_i) begin
      round_q <= (dir_i == CIPH_FWD) ? '0 : aes_round_t'(NumRounds);
      dir_q   <= dir_i;
    end else if (step_i) begin
      round_q <= (dir_q == CIPH_FWD) ? round_q + 1'b1 : round_q - 1'b1;
    end
  end

  // Run ends at the top round forward, at round 0 inverse
  assign last_round_o = (dir_q == CIPH_FWD) ? (round_q == aes_round_t'(NumRounds)) :
                                              (round_q == '0);
  assign round_o      = round_q;

  // Never past the top round in either direction
  round_in_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    round_q <= aes_round_t'(NumRounds));

endmodule

`default_nettype wire

// File: source/aes_rcon_gen.sv
////////////////////////////////////////////////////////////////////////////
// Rcon generator
// Holds the round constant, multiplies or divides it by x per step
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module aes_rcon_gen import aes_key_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      load_i,
  input  logic      step_i,
  input  ciph_dir_e dir_i,
  input  logic      active_i,
  output aes_byte_t rcon_o
);

  aes_byte_t rcon_q, rcon_d;
  ciph_dir_e dir_q;

  // Next constant
  // Load picks the start value of the new direction
  always_comb begin : rcon_next
    if (load_i) begin
      rcon_d = (dir_i == CIPH_FWD) ? RconFwdInit : RconInvInit;
    end else if (dir_q == CIPH_FWD) begin
      rcon_d = aes_mul2(rcon_q);
    end else begin
      rcon_d = aes_div2(rcon_q);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : rcon_reg
    if (!rst_ni) begin
      rcon_q <= '0;
      dir_q  <= CIPH_FWD;
    end else begin
      if (load_i) begin
        dir_q <= dir_i;
      end
      if (load_i || step_i) begin
        rcon_q <= rcon_d;
      end
    end
  end

  assign rcon_o = rcon_q;

  // A zero constant would mean a missed load before the key went valid
  rcon_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    active_i |-> (rcon_o != '0));

endmodule

`default_nettype wire

// File: source/aes_key_round.sv
////////////////////////////////////////////////////////////////////////////
// Round-key register and AES-128 word expansion
// Forward and inverse next-key logic around a shared SubWord
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module aes_key_round import aes_key_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      load_i,
  input  logic      step_i,
  input  ciph_dir_e dir_i,
  input  aes_key_t  key_i,
  input  aes_byte_t rcon_i,
  output aes_key_t  round_key_o
);

  aes_key_t        key_q;
  ciph_dir_e       dir_q;

  // Word views of the current and next key
  aes_word_t [3:0] cur_w;
  aes_word_t [3:0] nxt_w;

  // Word 3 of the previous round key, recovered for the inverse walk
  aes_word_t       prev_w3;
  aes_word_t       sub_in;
  aes_word_t       sub_out;
  aes_word_t       irregular;

  assign cur_w = key_q;

  ////////////////////////////////////////////////////////////////////////////
  // RotWord, SubWord and Rcon
  ////////////////////////////////////////////////////////////////////////////

  assign prev_w3 = cur_w[3] ^ cur_w[2];

  // Forward uses the current word 3, inverse the recovered one
  assign sub_in = aes_rot_word((dir_q == CIPH_FWD) ? cur_w[3] : prev_w3);

  // One S-box per byte lane
  for (genvar i = 0; i < 4; i++) begin : gen_sbox
    aes_sbox_lut u_sbox (
      .data_i ( sub_in[8*i +: 8]  ),
      .data_o ( sub_out[8*i +: 8] )
    );
  end

  // Rcon only touches byte 0
  assign irregular = sub_out ^ {24'h00_0000, rcon_i};

  ////////////////////////////////////////////////////////////////////////////
  // Word expansion
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : next_key
    if (dir_q == CIPH_FWD) begin
      // Chain up from word 0
      nxt_w[0] = irregular ^ cur_w[0];
      for (int i = 1; i < 4; i++) begin
        nxt_w[i] = nxt_w[i-1] ^ cur_w[i];
      end
    end else begin
      // Undo the chain, word 0 last
      for (int i = 1; i < 4; i++) begin
        nxt_w[i] = cur_w[i] ^ cur_w[i-1];
      end
      nxt_w[0] = cur_w[0] ^ irregular;
    end
  end

  // Key register, direction latched with the key
  always_ff @(posedge clk_i or negedge rst_ni) begin : key_reg
    if (!rst_ni) begin
      key_q <= '0;
      dir_q <= CIPH_FWD;
    end else if (load_i) begin
      key_q <= key_i;
      dir_q <= dir_i;
    end else if (step_i) begin
      key_q <= nxt_w;
    end
  end

  assign round_key_o = key_q;

endmodule

`default_nettype wire

// File: source/aes_key_sched.sv
////////////////////////////////////////////////////////////////////////////
// AES-128 round-key generator, top level
// Connects the controller, round counter, Rcon generator and key datapath
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module aes_key_sched import aes_key_pkg::*; #(
  parameter int NumRounds = aes_key_pkg::NumRounds
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       start_i,
  input  ciph_dir_e  dir_i,
  input  aes_key_t   key_i,
  input  logic       advance_i,
  output aes_key_t   round_key_o,
  output aes_round_t round_o,
  output logic       key_valid_o,
  output logic       busy_o,
  output logic       done_o
);

  // Strobes from the controller
  logic      load;
  logic      step;
  // Counter feedback
  logic      last_round;
  logic      key_valid;
  aes_byte_t rcon;

  aes_key_sched_fsm #(
    .NumRounds ( NumRounds )
  ) u_fsm (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .start_i      ( start_i    ),
    .advance_i    ( advance_i  ),
    .last_round_i ( last_round ),
    .load_o       ( load       ),
    .step_o       ( step       ),
    .key_valid_o  ( key_valid  ),
    .busy_o       ( busy_o     ),
    .done_o       ( done_o     )
  );

  aes_round_counter #(
    .NumRounds ( NumRounds )
  ) u_round_counter (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .load_i       ( load       ),
    .step_i       ( step       ),
    .dir_i        ( dir_i      ),
    .round_o      ( round_o    ),
    .last_round_o ( last_round )
  );

  aes_rcon_gen u_rcon_gen (
    .clk_i    ( clk_i     ),
    .rst_ni   ( rst_ni    ),
    .load_i   ( load      ),
    .step_i   ( step      ),
    .dir_i    ( dir_i     ),
    .active_i ( key_valid ),
    .rcon_o   ( rcon      )
  );

  aes_key_round u_key_round (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .load_i      ( load        ),
    .step_i      ( step        ),
    .dir_i       ( dir_i       ),
    .key_i       ( key_i       ),
    .rcon_i      ( rcon        ),
    .round_key_o ( round_key_o )
  );

  assign key_valid_o = key_valid;

endmodule

`default_nettype wire

// File: verification/tb_aes_key_sched.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the AES-128 round-key generator
// Vector file reader, random back-pressure, stray start strobes,
// typed compare tasks and a watchdog
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_aes_key_sched import aes_key_pkg::*;;

  localparam int ClkPeriod   = 40;
  localparam int ResetCycles = 16;
  localparam int NumRecords  = 4;
  localparam int KeysPerRun  = NumRounds + 1;
  // Worst-case cycles per round under random stalls
  localparam int StallMargin = 8;
  localparam int TimeoutNs   = (NumRecords * KeysPerRun * StallMargin + ResetCycles) * ClkPeriod;

  logic       clk;
  logic       rst_n;
  logic       start;
  ciph_dir_e  dir;
  aes_key_t   key;
  logic       advance;
  aes_key_t   round_key;
  aes_round_t round;
  logic       key_valid;
  logic       busy;
  logic       done;

  // Vectors from the data file
  ciph_dir_e  rec_dir[$];
  aes_key_t   rec_key[$];
  aes_key_t   exp_q[$];

  int         errors = 0;
  int         checks = 0;
  integer     seed   = 32'h5028_1195;

  aes_key_sched uut (
    .clk_i       ( clk       ),
    .rst_ni      ( rst_n     ),
    .start_i     ( start     ),
    .dir_i       ( dir       ),
    .key_i       ( key       ),
    .advance_i   ( advance   ),
    .round_key_o ( round_key ),
    .round_o     ( round     ),
    .key_valid_o ( key_valid ),
    .busy_o      ( busy      ),
    .done_o      ( done      )
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_key(input string name, input aes_key_t exp, input aes_key_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s expected %h got %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_round(input string name, input aes_round_t exp, input aes_round_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s expected %h got %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s expected %h got %h at %0t", name, exp, act, $time);
    end
  endtask

  // Round shown for the idx-th key of a run
  function automatic aes_round_t expected_round(input ciph_dir_e d, input int idx);
    return (d == CIPH_FWD) ? aes_round_t'(idx) : aes_round_t'(NumRounds - idx);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Vector file
  ////////////////////////////////////////////////////////////////////////////

  // Record: D <dir> <load key>, then 11 expected keys; '#' starts a comment line
  task automatic read_vectors();
    int                fd;
    int                code;
    int                ch;
    int                d;
    logic [8*16-1:0]   tok;
    aes_key_t          k;
    bit                finished;
    fd = $fopen("verification/aes_key_sched_testdata.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the test data file");
    end else begin
      finished = 1'b0;
      while (!finished) begin
        code = $fscanf(fd, "%s", tok);
        if (code != 1) begin
          finished = 1'b1;
        end else if (tok == "#") begin
          ch = $fgetc(fd);
          while (ch != 10 && ch != -1) ch = $fgetc(fd);
        end else if (tok == "D") begin
          code = $fscanf(fd, "%d %h", d, k);
          rec_dir.push_back(ciph_dir_e'(d[0]));
          rec_key.push_back(k);
          for (int i = 0; i < KeysPerRun; i++) begin
            code = $fscanf(fd, "%h", k);
            exp_q.push_back(k);
          end
        end else begin
          errors++;
          $display("Unexpected token in the test data file");
          finished = 1'b1;
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // One schedule run
  ////////////////////////////////////////////////////////////////////////////

  // Entered and left on a falling edge
  task automatic run_record(input int rec);
    int         idx;
    int         base;
    logic       adv;
    bit         stray_sent;
    base       = rec * KeysPerRun;
    stray_sent = 1'b0;
    start      = 1'b1;
    dir        = rec_dir[rec];
    key        = rec_key[rec];
    advance    = 1'b0;
    @(negedge clk);
    // Inputs change after the load, design keeps its own copies
    start = 1'b0;
    dir   = (rec_dir[rec] == CIPH_FWD) ? CIPH_INV : CIPH_FWD;
    key   = ~rec_key[rec];
    check_key("round_key_o", rec_key[rec], round_key);
    idx = 0;
    while (idx < KeysPerRun) begin
      check_flag("key_valid_o", 1'b1, key_valid);
      check_flag("busy_o", 1'b1, busy);
      check_flag("done_o", 1'b0, done);
      // A stalled cycle keeps idx, so the held key and round are expected again
      check_key("round_key_o", exp_q[base + idx], round_key);
      check_round("round_o", expected_round(rec_dir[rec], idx), round);
      // Advance with probability 3/4
      adv     = (($random(seed) & 3) != 0);
      advance = adv;
      // One start strobe mid-run, must be ignored while busy
      start = 1'b0;
      if (!stray_sent && idx == KeysPerRun / 2) begin
        start      = 1'b1;
        stray_sent = 1'b1;
      end
      if (adv) idx++;
      @(negedge clk);
    end
    advance = 1'b0;
    start   = 1'b0;
    // Cycle after the final advance
    check_flag("done_o", 1'b1, done);
    check_flag("key_valid_o", 1'b0, key_valid);
    check_flag("busy_o", 1'b0, busy);
    @(negedge clk);
    check_flag("done_o", 1'b0, done);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main_seq
    rst_n   = 1'b0;
    start   = 1'b0;
    dir     = CIPH_FWD;
    key     = '0;
    advance = 1'b0;
    read_vectors();
    repeat (ResetCycles) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    // Idle state out of reset
    check_flag("key_valid_o", 1'b0, key_valid);
    check_flag("busy_o", 1'b0, busy);
    check_flag("done_o", 1'b0, done);
    check_round("round_o", '0, round);
    check_key("round_key_o", '0, round_key);
    if (rec_dir.size() != NumRecords || exp_q.size() != NumRecords * KeysPerRun) begin
      errors++;
      $display("The test data file holds %0d records instead of %0d", rec_dir.size(),
               NumRecords);
    end else begin
      for (int r = 0; r < NumRecords; r++) begin
        run_record(r);
      end
    end
    $display("Errors: %0d in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Bound on the whole run
  initial begin : watchdog
    #(TimeoutNs);
    $display("Timeout: the key schedule runs did not finish within %0d ns", TimeoutNs);
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/aes_key_sched_testdata.txt
# D <dir: 0 forward, 1 inverse> <load key>, then 11 expected round keys in output order
# Keys are 128-bit hex, word 0 in bits 31:0, byte 0 of each word in its low 8 bits
D 0 3c4fcf098815f7aba6d2ae2816157e2b
3c4fcf098815f7aba6d2ae2816157e2b 05766c2a3939a323b12c548817fefaa0
7ff659737a80355943b9967af295c2f2 3b887a6d447e231e3efe16477d47803d
00ad0bdb3b2571b67f5b52a841a544ef bc15f911bcb8f2ca879d837cf8c6d1d4
fd9300ca4186f9dbfd3e0b117aa3886d 4fdca64eb24fa684f3c95f5f0ef7544e
2f298d7f60f52b31d2ba8db52173d2ea 6e005c574129d12821dcfa19f36677ac
a60c63b6c80c3fe18925eec9a8f914d0
D 1 a60c63b6c80c3fe18925eec9a8f914d0
a60c63b6c80c3fe18925eec9a8f914d0 6e005c574129d12821dcfa19f36677ac
2f298d7f60f52b31d2ba8db52173d2ea 4fdca64eb24fa684f3c95f5f0ef7544e
fd9300ca4186f9dbfd3e0b117aa3886d bc15f911bcb8f2ca879d837cf8c6d1d4
00ad0bdb3b2571b67f5b52a841a544ef 3b887a6d447e231e3efe16477d47803d
7ff659737a80355943b9967af295c2f2 05766c2a3939a323b12c548817fefaa0
3c4fcf098815f7aba6d2ae2816157e2b
D 0 00000000000000000000000000000000
00000000000000000000000000000000 63636362636363626363636263636362
aafbfbf9c998989baafbfbf9c998989b 99ac0f0b3357f4f2facf6c6950349790
2bee917eb2429e7581156a877bda06ee 90924bf3bb7cda8d093e44f8882b2e7f
a79bb46a3709ff998c752514854b61ec 9bf01bc63c6bafac0b62503587177521
9ffa1d51040a06973861a93b3303f90e 4149664cdeb37b1ddab97d8ae2d8d4b1
8e188f6fcf51e92311e2923ecb5befb4
D 1 26c3d78c85d7d2827bf072e488350ad6
26c3d78c85d7d2827bf072e488350ad6 a314050efe27a066f3c57832233ff08b
5d33a5680de2d854d0fa88b966733396 50d17d3cdd1850edb689bb2f8d200de9
8dc92dd16b91ebc23ba9b6c6b37dd071 e658c61350385d0488d466b7cef3bae5
b6609b17d8ec3bb34627dc523ebd6ae1 6e8ca0a49ecbe7e1789ab6b377220e09
f0474745e65151520fb8b8ba19aeaead 16161617e9e9e9e816161617e9e9e9e8
ffffffffffffffffffffffffffffffff

// File: aes_key_sched.f
source/aes_key_pkg.sv
source/aes_sbox_lut.sv
source/aes_key_sched_fsm.sv
source/aes_round_counter.sv
source/aes_rcon_gen.sv
source/aes_key_round.sv
source/aes_key_sched.sv
verification/tb_aes_key_sched.sv
